// File: design/memwb_defs.svh
`ifndef MEMWB_DEFS_SVH
`define MEMWB_DEFS_SVH

// Register and bus word width
`define MW_DATA_WIDTH 32

// Number of general registers
`define MW_REG_COUNT 32

// Bits needed to name one register
`define MW_REG_IDX_W 5

// Byte address width on the data side
`define MW_ADDR_WIDTH 32

`endif

// File: design/cpuPkg.sv
`include "memwb_defs.svh"

package cpuPkg;

   // Memory access width
   typedef enum logic [1:0] {
      sizeByte = 2'd0,
      sizeHalf = 2'd1,
      sizeWord = 2'd2
   } accessSize;

   // What goes into rd once the command finishes
   typedef enum logic [1:0] {
      wbResult = 2'd0,
      wbLink   = 2'd1,
      wbLoad   = 2'd2,
      wbNone   = 2'd3
   } wbSource;

   // One command from the execute side
   typedef struct packed {
      logic                         isStore;
      accessSize                    size;
      wbSource                      src;
      // Destination, or the store-data register for a store
      logic [`MW_REG_IDX_W-1:0]     rd;
      // ALU result, or the byte address for loads and stores
      logic [`MW_DATA_WIDTH-1:0]    result;
      // Word-aligned return address
      logic [`MW_ADDR_WIDTH-3:0]    pcLink;
   } wbCmd;

endpackage

// File: design/busPkg.sv
`include "memwb_defs.svh"

package busPkg;

   // Requester to completer
   typedef struct packed {
      logic                          psel;
      logic                          penable;
      logic                          pwrite;
      logic [`MW_ADDR_WIDTH-1:0]     paddr;
      logic [`MW_DATA_WIDTH-1:0]     pwdata;
      // One bit per byte lane
      logic [`MW_DATA_WIDTH/8-1:0]   pstrb;
   } apbReq;

   // Completer to requester
   typedef struct packed {
      logic [`MW_DATA_WIDTH-1:0]     prdata;
      logic                          pready;
      logic                          pslverr;
   } apbRsp;

endpackage

// File: design/regFile.sv
`timescale 1ns/1ns
`include "memwb_defs.svh"

module regFile (
   input  logic                       gclk,
   input  logic                       rstN,
   input  logic                       wrEn,
   input  logic [`MW_REG_IDX_W-1:0]   wrIdx,
   input  logic [`MW_DATA_WIDTH-1:0]  wrData,
   input  logic [`MW_REG_IDX_W-1:0]   raIdx,
   input  logic [`MW_REG_IDX_W-1:0]   rbIdx,
   input  logic [`MW_REG_IDX_W-1:0]   rdIdx,
   output logic [`MW_DATA_WIDTH-1:0]  regA,
   output logic [`MW_DATA_WIDTH-1:0]  regB,
   output logic [`MW_DATA_WIDTH-1:0]  regD
);

   // Storage for all entries, entry zero never written
   logic [`MW_DATA_WIDTH-1:0] regs [`MW_REG_COUNT];

   // Single write port, held off during reset, index zero dropped
   always_ff @(posedge gclk) begin
      if (rstN && wrEn && (wrIdx != '0)) begin
         regs[wrIdx] <= wrData;
      end
   end

   // Three combinational read ports
   // Register zero reads as zero whatever sits in the array
   assign regA = (raIdx == '0) ? '0 : regs[raIdx];
   assign regB = (rbIdx == '0) ? '0 : regs[rbIdx];
   assign regD = (rdIdx == '0) ? '0 : regs[rdIdx];

endmodule

// File: design/byteLaneSizer.sv
`timescale 1ns/1ns
`include "memwb_defs.svh"

module byteLaneSizer (
   input  cpuPkg::accessSize            size,
   input  logic [1:0]                   laneAddr,
   input  logic [`MW_DATA_WIDTH-1:0]    storeOperand,
   input  logic [`MW_DATA_WIDTH-1:0]    readWord,
   output logic [`MW_DATA_WIDTH/8-1:0]  strobe,
   output logic [`MW_DATA_WIDTH-1:0]    storeWord,
   output logic [`MW_DATA_WIDTH-1:0]    loadValue
);

   // Byte picked out of the read word by lane
   logic [7:0] laneByte;

   always_comb begin
      case (laneAddr)
         2'd0: laneByte = readWord[7:0];
         2'd1: laneByte = readWord[15:8];
         2'd2: laneByte = readWord[23:16];
         default: laneByte = readWord[31:24];
      endcase
   end

   always_comb begin
      case (size)
         cpuPkg::sizeByte: begin
            // One lane, picked by both low address bits
            strobe    = 4'b0001 << laneAddr;
            storeWord = {4{storeOperand[7:0]}};
            loadValue = {24'd0, laneByte};
         end
         cpuPkg::sizeHalf: begin
            // Address bit 1 chooses upper or lower half
            strobe    = laneAddr[1] ? 4'b1100 : 4'b0011;
            storeWord = {2{storeOperand[15:0]}};
            if (laneAddr[1]) begin
               loadValue = {16'd0, readWord[31:16]};
            end else begin
               loadValue = {16'd0, readWord[15:0]};
            end
         end
         default: begin
            // Full word, also covers the unused code
            strobe    = 4'b1111;
            storeWord = storeOperand;
            loadValue = readWord;
         end
      endcase
   end

endmodule

// File: design/apbRequester.sv
`timescale 1ns/1ns
`include "memwb_defs.svh"

module apbRequester (
   input  logic                         gclk,
   input  logic                         rstN,
   input  logic                         start,
   input  logic                         write,
   input  logic [`MW_ADDR_WIDTH-1:0]    addr,
   input  logic [`MW_DATA_WIDTH-1:0]    wdata,
   input  logic [`MW_DATA_WIDTH/8-1:0]  strb,
   input  busPkg::apbRsp                apbRsp,
   output busPkg::apbReq                apbReq,
   output logic                         done,
   output logic [`MW_DATA_WIDTH-1:0]    rdata,
   output logic                         busError
);

   typedef enum logic [1:0] {
      stIdle,
      stSetup,
      stAccess
   } apbState;

   apbState state;

   // Transfer fields, held from setup until completion
   logic [`MW_ADDR_WIDTH-1:0]    addrQ;
   logic [`MW_DATA_WIDTH-1:0]    wdataQ;
   logic [`MW_DATA_WIDTH/8-1:0]  strbQ;
   logic                         writeQ;

   always_ff @(posedge gclk or negedge rstN) begin
      if (!rstN) begin
         state <= stIdle;
      end else begin
         case (state)
            stIdle: if (start) state <= stSetup;
            stSetup: state <= stAccess;
            // Wait states until the completer answers
            stAccess: if (apbRsp.pready) state <= stIdle;
            default: state <= stIdle;
         endcase
      end
   end

   // Capture at start, word-aligned address
   always_ff @(posedge gclk) begin
      if (state == stIdle && start) begin
         addrQ  <= {addr[`MW_ADDR_WIDTH-1:2], 2'b00};
         wdataQ <= wdata;
         strbQ  <= strb;
         writeQ <= write;
      end
   end

   // Error shows one cycle after the completion edge
   always_ff @(posedge gclk or negedge rstN) begin
      if (!rstN) begin
         busError <= 1'b0;
      end else begin
         busError <= done && apbRsp.pslverr;
      end
   end

   always_comb begin
      apbReq.psel    = (state != stIdle);
      apbReq.penable = (state == stAccess);
      apbReq.pwrite  = writeQ;
      apbReq.paddr   = addrQ;
      apbReq.pwdata  = wdataQ;
      apbReq.pstrb   = strbQ;
   end

   // Completion cycle
   assign done  = (state == stAccess) && apbRsp.pready;
   assign rdata = apbRsp.prdata;

endmodule

// File: design/wbSequencer.sv
`timescale 1ns/1ns
`include "memwb_defs.svh"

module wbSequencer (
   input  logic                         gclk,
   input  logic                         rstN,
   input  logic                         cmdValid,
   input  cpuPkg::wbCmd                 cmd,
   input  logic                         memDone,
   input  logic [`MW_DATA_WIDTH-1:0]    loadValue,
   input  logic [`MW_DATA_WIDTH-1:0]    regD,
   output logic                         cmdReady,
   output logic                         memStart,
   output logic                         memWrite,
   output logic [`MW_ADDR_WIDTH-1:0]    memAddr,
   output cpuPkg::accessSize            accSize,
   output logic [1:0]                   laneAddr,
   output logic [`MW_DATA_WIDTH-1:0]    storeOperand,
   output logic [`MW_REG_IDX_W-1:0]     rdIdx,
   output logic                         wrEn,
   output logic [`MW_REG_IDX_W-1:0]     wrIdx,
   output logic [`MW_DATA_WIDTH-1:0]    wrData
);

   // High while a load or store is out on the bus
   logic busy;
   // Memory command kept for the whole transfer
   cpuPkg::wbCmd heldCmd;
   // Live command when idle, held one while busy
   cpuPkg::wbCmd activeCmd;
   logic accept;
   logic cmdIsMem;
   logic heldIsLoad;

   assign cmdReady   = !busy;
   assign accept     = cmdValid && !busy;
   assign cmdIsMem   = cmd.isStore || (cmd.src == cpuPkg::wbLoad);
   assign heldIsLoad = !heldCmd.isStore && (heldCmd.src == cpuPkg::wbLoad);
   assign activeCmd  = busy ? heldCmd : cmd;

   always_ff @(posedge gclk or negedge rstN) begin
      if (!rstN) begin
         busy <= 1'b0;
      end else if (accept && cmdIsMem) begin
         busy <= 1'b1;
      end else if (busy && memDone) begin
         // Ready reopens the cycle after completion
         busy <= 1'b0;
      end
   end

   always_ff @(posedge gclk) begin
      if (accept && cmdIsMem) begin
         heldCmd <= cmd;
      end
   end

   // Requester latches these in the accepting cycle
   assign memStart = accept && cmdIsMem;
   assign memWrite = activeCmd.isStore;
   assign memAddr  = activeCmd.result;

   // Sizer sees the same lane for the strobe and for the load
   assign accSize  = activeCmd.size;
   assign laneAddr = activeCmd.result[1:0];

   // Store data comes from the register named by rd
   assign rdIdx        = activeCmd.rd;
   assign storeOperand = regD;

   assign wrIdx = activeCmd.rd;

   always_comb begin
      wrEn = 1'b0;
      if (accept && !cmdIsMem) begin
         // Non-memory commands write on the accepting edge
         wrEn = (cmd.src != cpuPkg::wbNone);
      end else if (busy && memDone) begin
         // Loads write on the completion edge, errors included
         wrEn = heldIsLoad;
      end
   end

   // Writeback source mux
   always_comb begin
      case (activeCmd.src)
         cpuPkg::wbResult: wrData = activeCmd.result;
         cpuPkg::wbLink: wrData = {activeCmd.pcLink, 2'b00};
         cpuPkg::wbLoad: wrData = loadValue;
         default: wrData = activeCmd.result;
      endcase
   end

endmodule

// File: design/memWriteback.sv
`timescale 1ns/1ns
`include "memwb_defs.svh"

module memWriteback (
   input  logic                        gclk,
   input  logic                        rstN,
   input  logic                        cmdValid,
   input  cpuPkg::wbCmd                cmd,
   input  logic [`MW_REG_IDX_W-1:0]    raIdx,
   input  logic [`MW_REG_IDX_W-1:0]    rbIdx,
   input  busPkg::apbRsp               apbRsp,
   output logic                        cmdReady,
   output logic [`MW_DATA_WIDTH-1:0]   regA,
   output logic [`MW_DATA_WIDTH-1:0]   regB,
   output busPkg::apbReq               apbReq,
   output logic                        busError
);

   // Sequencer to requester
   logic                         memStart;
   logic                         memWrite;
   logic                         memDone;
   logic [`MW_ADDR_WIDTH-1:0]    memAddr;
   logic [`MW_DATA_WIDTH-1:0]    memRdata;

   // Sequencer and sizer
   cpuPkg::accessSize            accSize;
   logic [1:0]                   laneAddr;
   logic [`MW_DATA_WIDTH-1:0]    storeOperand;
   logic [`MW_DATA_WIDTH/8-1:0]  strobe;
   logic [`MW_DATA_WIDTH-1:0]    storeWord;
   logic [`MW_DATA_WIDTH-1:0]    loadValue;

   // Register file side
   logic                         wrEn;
   logic [`MW_REG_IDX_W-1:0]     wrIdx;
   logic [`MW_DATA_WIDTH-1:0]    wrData;
   logic [`MW_REG_IDX_W-1:0]     rdIdx;
   logic [`MW_DATA_WIDTH-1:0]    regD;

   wbSequencer i_wbSequencer (
      .gclk(gclk), .rstN(rstN),
      .cmdValid(cmdValid), .cmd(cmd), .cmdReady(cmdReady),
      .memDone(memDone), .loadValue(loadValue), .regD(regD),
      .memStart(memStart), .memWrite(memWrite), .memAddr(memAddr),
      .accSize(accSize), .laneAddr(laneAddr), .storeOperand(storeOperand),
      .rdIdx(rdIdx), .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData)
   );

   byteLaneSizer i_byteLaneSizer (
      .size(accSize), .laneAddr(laneAddr),
      .storeOperand(storeOperand), .readWord(memRdata),
      .strobe(strobe), .storeWord(storeWord), .loadValue(loadValue)
   );

   apbRequester i_apbRequester (
      .gclk(gclk), .rstN(rstN),
      .start(memStart), .write(memWrite), .addr(memAddr),
      .wdata(storeWord), .strb(strobe), .apbRsp(apbRsp),
      .apbReq(apbReq), .done(memDone), .rdata(memRdata), .busError(busError)
   );

   regFile i_regFile (
      .gclk(gclk), .rstN(rstN),
      .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData),
      .raIdx(raIdx), .rbIdx(rbIdx), .rdIdx(rdIdx),
      .regA(regA), .regB(regB), .regD(regD)
   );

endmodule

// File: verif/memWriteback_properties.sv
`timescale 1ns/1ns
`include "memwb_defs.svh"

module memWriteback_properties (
   input  logic                        gclk,
   input  logic                        rstN,
   input  busPkg::apbReq               apbReq,
   input  busPkg::apbRsp               apbRsp,
   input  logic [`MW_REG_IDX_W-1:0]    raIdx,
   input  logic [`MW_DATA_WIDTH-1:0]   regA
);

   // Failures seen so far, read by the testbench
   int assertFails = 0;

   // Access phase comes right after setup
   penableAfterSetup: assert property (@(posedge gclk) disable iff (!rstN)
      apbReq.psel && !apbReq.penable |=> apbReq.psel && apbReq.penable)
      else begin
         $error("penable did not follow an APB setup cycle");
         assertFails++;
      end

   // Transfer fields frozen until pready
   addrDataStable: assert property (@(posedge gclk) disable iff (!rstN)
      apbReq.psel && !apbRsp.pready |=> $stable(apbReq.paddr) && $stable(apbReq.pwdata))
      else begin
         $error("paddr or pwdata changed during an APB transfer");
         assertFails++;
      end

   regZeroReadsZero: assert property (@(posedge gclk) raIdx == '0 |-> regA == '0)
      else begin
         $error("register zero read nonzero on port A");
         assertFails++;
      end

endmodule

bind memWriteback memWriteback_properties i_memWriteback_properties (
   .gclk(gclk), .rstN(rstN), .apbReq(apbReq), .apbRsp(apbRsp),
   .raIdx(raIdx), .regA(regA)
);

// File: verif/memWriteback_tb.sv
`timescale 1ns/1ns
`include "memwb_defs.svh"

module memWriteback_tb;

   localparam logic [31:0] SEED = 32'h2942fa03;
   // Fill, tests 1 to 5, then the mixed run
   localparam int TOTAL_CMDS = 31 + 40 + 48 + 48 + 40 + 6 + 400;
   // Slowest memory command plus read-back is six cycles
   localparam int CYCLE_LIMIT = TOTAL_CMDS * 6 + 100;

   logic                        gclk;
   logic                        rstN;
   logic                        cmdValid;
   cpuPkg::wbCmd                cmd;
   logic [`MW_REG_IDX_W-1:0]    raIdx;
   logic [`MW_REG_IDX_W-1:0]    rbIdx;
   busPkg::apbRsp               apbRsp;
   logic                        cmdReady;
   logic [`MW_DATA_WIDTH-1:0]   regA;
   logic [`MW_DATA_WIDTH-1:0]   regB;
   busPkg::apbReq               apbReq;
   logic                        busError;

   // Register and memory models
   logic [31:0] regModel [`MW_REG_COUNT];
   logic [31:0] mem [64];
   logic [31:0] stimState;
   logic [31:0] waitState;
   int waitLeft;
   int xferCount;
   int errPulses;
   int expErrs;
   int cycleCount;
   int checkCount;
   int errorCount;
   int testStartErrs;

   memWriteback i_memWriteback (
      .gclk(gclk), .rstN(rstN), .cmdValid(cmdValid), .cmd(cmd),
      .raIdx(raIdx), .rbIdx(rbIdx), .apbRsp(apbRsp), .cmdReady(cmdReady),
      .regA(regA), .regB(regB), .apbReq(apbReq), .busError(busError)
   );

   initial begin
      gclk = 1'b0;
      forever #5 gclk = ~gclk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [31:0] nextRand();
      stimState = xorshift(stimState);
      return stimState;
   endfunction

   task automatic checkVal(input logic [31:0] got, input logic [31:0] exp, input string what);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Lanes from the access rules, first byte aligned down to the size
   task automatic laneModel(input cpuPkg::accessSize size, input logic [1:0] lane,
         input logic [31:0] operand, input logic [31:0] word,
         output logic [3:0] strb, output logic [31:0] wdata, output logic [31:0] loadv);
      int nBytes;
      int first;
      nBytes = (size == cpuPkg::sizeByte) ? 1 : ((size == cpuPkg::sizeHalf) ? 2 : 4);
      first = int'(lane) & (4 - nBytes);
      for (int b = 0; b < 4; b++) begin
         strb[b] = (b >= first) && (b < first + nBytes);
         wdata[8*b +: 8] = operand[8*(b % nBytes) +: 8];
      end
      loadv = word >> (8 * first);
      if (nBytes < 4) begin
         loadv = loadv & ((32'h1 << (8 * nBytes)) - 1);
      end
   endtask

   // Kind 0 register, 1 store, 2 load, 3 either access, 4 anything
   function automatic cpuPkg::wbCmd randCmd(input int kind);
      cpuPkg::wbCmd c;
      logic [31:0] r;
      logic [31:0] link;
      logic [7:0] byteAddr;
      int pick;
      r = nextRand();
      link = nextRand();
      c.rd = r[4:0];
      c.result = nextRand();
      c.pcLink = link[31:2];
      c.isStore = 1'b0;
      c.size = cpuPkg::sizeWord;
      c.src = cpuPkg::wbResult;
      pick = kind;
      if (kind == 3) begin
         pick = r[5] ? 1 : 2;
      end else if (kind == 4) begin
         pick = (r[6:5] == 2'd0) ? 1 : ((r[6:5] == 2'd1) ? 2 : 0);
      end
      if (pick == 0) begin
         if (r[9:8] == 2'd0) c.src = cpuPkg::wbLink;
         if (r[9:8] == 2'd1) c.src = cpuPkg::wbNone;
      end else begin
         if (r[11:10] == 2'd0) c.size = cpuPkg::sizeByte;
         if (r[11:10] == 2'd1) c.size = cpuPkg::sizeHalf;
         byteAddr = r[19:12];
         if (c.size == cpuPkg::sizeHalf) byteAddr[0] = 1'b0;
         if (c.size == cpuPkg::sizeWord) byteAddr[1:0] = 2'b00;
         c.result = {24'd0, byteAddr};
         c.isStore = (pick == 1);
         c.src = (pick == 1) ? cpuPkg::wbNone : cpuPkg::wbLoad;
      end
      return c;
   endfunction

   // Walks size and lane by index so all combinations show up
   function automatic cpuPkg::wbCmd sweepCmd(input int kind, input int i);
      cpuPkg::wbCmd c;
      logic [1:0] lane;
      c = randCmd(kind);
      lane = 2'(i / 3);
      c.size = cpuPkg::accessSize'(i % 3);
      if (c.size == cpuPkg::sizeHalf) lane[0] = 1'b0;
      if (c.size == cpuPkg::sizeWord) lane = 2'b00;
      c.result[1:0] = lane;
      return c;
   endfunction

   // Issue one command, follow its bus transfer, update the model
   task automatic runCmd(input cpuPkg::wbCmd c);
      logic isMem;
      logic [3:0] strb;
      logic [31:0] wdata;
      logic [31:0] loadv;
      int lat;
      int setups;
      int xferStart;
      isMem = c.isStore || (c.src == cpuPkg::wbLoad);
      laneModel(c.size, c.result[1:0], regModel[c.rd], mem[c.result[7:2]], strb, wdata, loadv);
      cmd = c;
      cmdValid = 1'b1;
      while (!cmdReady) @(negedge gclk);
      @(negedge gclk);
      cmdValid = 1'b0;
      if (isMem) begin
         if (c.result[7:2] == 6'd63) expErrs++;
         lat = 0;
         setups = 0;
         xferStart = xferCount;
         while (!cmdReady) begin
            if (apbReq.psel) begin
               if (!apbReq.penable) setups++;
               checkVal(apbReq.paddr, {c.result[31:2], 2'b00}, "paddr");
               checkVal(apbReq.pwrite, c.isStore, "pwrite");
               if (c.isStore) begin
                  checkVal(apbReq.pstrb, strb, "pstrb");
                  checkVal(apbReq.pwdata, wdata, "pwdata");
               end
            end
            @(negedge gclk);
            lat++;
         end
         checkVal(setups, 1, "setup cycles in one access");
         checkVal(xferCount - xferStart, 1, "completions before cmdReady rose");
         checkVal((lat >= 2) && (lat <= 4), 1, "cycles from accept to cmdReady");
         checkVal(apbReq.psel, 1'b0, "psel once cmdReady is back");
      end
      if (!c.isStore && (c.rd != '0)) begin
         case (c.src)
            cpuPkg::wbResult: regModel[c.rd] = c.result;
            cpuPkg::wbLink: regModel[c.rd] = {c.pcLink, 2'b00};
            cpuPkg::wbLoad: regModel[c.rd] = loadv;
            default: ;
         endcase
      end
   endtask

   // Combinational ports, sampled in the low phase
   task automatic readBack(input logic [4:0] a, input logic [4:0] b);
      raIdx = a;
      rbIdx = b;
      #2;
      checkVal(regA, regModel[a], $sformatf("regA of x%0d", a));
      checkVal(regB, regModel[b], $sformatf("regB of x%0d", b));
      @(negedge gclk);
   endtask

   task automatic finishTest(input string name);
      // busError lags completion by a cycle
      @(negedge gclk);
      checkVal(errPulses, expErrs, "busError pulse count");
      $display("Test %s finished with %0d errors", name, errorCount - testStartErrs);
      testStartErrs = errorCount;
   endtask

   // APB completer, 0 to 2 wait states, error on the top word
   always @(negedge gclk) begin
      apbRsp.pready = 1'b0;
      apbRsp.pslverr = 1'b0;
      if (rstN && apbReq.psel) begin
         if (!apbReq.penable) begin
            waitState = xorshift(waitState);
            waitLeft = waitState % 3;
         end else if (waitLeft > 0) begin
            waitLeft--;
         end else begin
            apbRsp.pready = 1'b1;
            apbRsp.prdata = mem[apbReq.paddr[7:2]];
            apbRsp.pslverr = (apbReq.paddr[7:2] == 6'd63);
            for (int b = 0; b < 4; b++) begin
               if (apbReq.pwrite && apbReq.pstrb[b]) begin
                  mem[apbReq.paddr[7:2]][8*b +: 8] = apbReq.pwdata[8*b +: 8];
               end
            end
         end
      end
   end

   // Completions and error pulses, cycle limit
   always @(posedge gclk) begin
      if (apbReq.psel && apbReq.penable && apbRsp.pready) xferCount++;
      if (busError) errPulses++;
      cycleCount++;
      if (cycleCount > CYCLE_LIMIT) begin
         $display("Run hung: tests did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Done: errors found");
         $finish;
      end
   end

   initial begin
      cpuPkg::wbCmd c;
      int totalErrs;
      stimState = SEED;
      waitState = xorshift(SEED ^ 32'h0000ffff);
      rstN = 1'b0;
      cmdValid = 1'b0;
      cmd = '0;
      raIdx = '0;
      rbIdx = '0;
      apbRsp = '0;
      regModel[0] = '0;
      for (int w = 0; w < 64; w++) begin
         mem[w] = {8'(w) ^ 8'hc3, 8'(w * 7), ~8'(w), 8'(w + 'h40)};
      end
      repeat (10) @(posedge gclk);
      @(negedge gclk);
      rstN = 1'b1;
      @(negedge gclk);

      checkVal(cmdReady, 1'b1, "cmdReady after reset");
      checkVal(apbReq.psel, 1'b0, "psel after reset");
      checkVal(busError, 1'b0, "busError after reset");
      // Every register gets a known value first
      for (int r = 1; r < `MW_REG_COUNT; r++) begin
         c = randCmd(0);
         c.src = cpuPkg::wbResult;
         c.rd = 5'(r);
         runCmd(c);
      end
      for (int i = 0; i < 40; i++) begin
         c = randCmd(0);
         if (i % 8 == 0) c.rd = '0;
         runCmd(c);
         readBack(c.rd, 5'(nextRand()));
      end
      finishTest("1 reset and register writes");

      for (int i = 0; i < 48; i++) runCmd(sweepCmd(1, i));
      finishTest("2 store lanes");

      for (int i = 0; i < 48; i++) begin
         c = sweepCmd(2, i);
         runCmd(c);
         readBack(c.rd, 5'(nextRand()));
      end
      finishTest("3 load lanes");

      for (int i = 0; i < 40; i++) runCmd(randCmd(3));
      finishTest("4 wait states");

      // Top word answers with pslverr
      c = randCmd(2);
      c.size = cpuPkg::sizeWord;
      c.result = 32'h0000_00fc;
      runCmd(c);
      readBack(c.rd, '0);
      c = randCmd(1);
      c.size = cpuPkg::sizeByte;
      c.result = 32'h0000_00fd;
      runCmd(c);
      c = randCmd(2);
      c.size = cpuPkg::sizeHalf;
      c.result = 32'h0000_00fe;
      runCmd(c);
      readBack(c.rd, '0);
      for (int i = 0; i < 3; i++) begin
         c = randCmd(4);
         runCmd(c);
         readBack(c.rd, 5'(nextRand()));
      end
      finishTest("5 bus error");

      for (int i = 0; i < 400; i++) runCmd(randCmd(4));
      for (int r = 0; r < `MW_REG_COUNT; r += 2) readBack(5'(r), 5'(r + 1));
      finishTest("6 mixed sequence");

      totalErrs = errorCount + i_memWriteback.i_memWriteback_properties.assertFails;
      $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
         checkCount, errorCount, i_memWriteback.i_memWriteback_properties.assertFails);
      if (totalErrs == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: filelist.f
+incdir+design
design/cpuPkg.sv
design/busPkg.sv
design/regFile.sv
design/byteLaneSizer.sv
design/apbRequester.sv
design/wbSequencer.sv
design/memWriteback.sv
verif/memWriteback_properties.sv
verif/memWriteback_tb.sv

// File: Bender.yml
package:
  name: memwb
  description: "Register file and APB data-memory writeback for a small load/store core"

sources:
  - include_dirs:
      - design
    files:
      - design/cpuPkg.sv
      - design/busPkg.sv
      - design/regFile.sv
      - design/byteLaneSizer.sv
      - design/apbRequester.sv
      - design/wbSequencer.sv
      - design/memWriteback.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/memWriteback_properties.sv
      - verif/memWriteback_tb.sv
